// File: tb_fme_input.txt
# partition word in hex with p64 in the low bits
# then cost done delay in cycles and expected pass length
00000000000 0 1088
2aaaaaaaaaa 4 1088
3ffffffffff 17 1088
15555555555 1 1088
1b4e29c6d72 3 1088
26c93b1e58a 40 1088
3c5a0f96e29 9 1088

// File: compile.f
fme_pkg.sv
fme_phase_fsm.sv
fme_block_walker.sv
fme_mv_path.sv
fme_ctrl_top.sv
tb_fme_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fme_ctrl
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SRCS      := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_fme_ctrl.sv
// fme controller testbench
// one ctu per input line, checks block walk, reads, requests and pass timing
module tb_fme_ctrl;
    timeunit 1ns;
    timeprecision 100ps;
    import fme_pkg::*;

    localparam int W = FMV_WIDTH_DEF;

    logic           clk;
    logic           rstn;
    logic           sysif_start_i;
    fme_partition_t fimeif_partition_i;
    logic [2*W-1:0] fimeif_mv_data_i;
    logic [2*W-1:0] mcif_mv_data_i;
    logic           cost_done_i;
    logic           sysif_done_o;
    logic           fimeif_mv_rden_o;
    logic [5:0]     fimeif_mv_rdaddr_o;
    logic           mcif_mv_rden_o;
    logic [5:0]     mcif_mv_rdaddr_o;
    logic           ref_rden_o;
    logic [7:0]     ref_idx_x_o;
    logic [7:0]     ref_idx_y_o;
    logic           ip_start_o;
    ip_req_t        ip_req_o;

    ip_mv_t         fime_mem [64];
    ip_mv_t         mc_mem [64];
    logic [6:0]     fime_rd;            // pending read, msb valid
    logic [6:0]     mc_rd;
    fme_partition_t part_cur;
    blk_idx_t       order_q [$];        // expected walk of the current ctu
    int             cycles;
    int             limit;

    fme_ctrl_top fme_ctrl_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ************************************************************************
    // compare tasks
    // ************************************************************************
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_ctrl(input logic [3:0] exp);    // fime, mc, ref, ip_start
        logic [3:0] got;
        got = {fimeif_mv_rden_o, mcif_mv_rden_o, ref_rden_o, ip_start_o};
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0d ns: rden/ip_start %b, expected %b",
                               $time, got, exp));
        end
    endtask

    task automatic check_done(input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0d ns: sysif_done_o %b, expected %b",
                               $time, got, exp));
        end
    endtask

    task automatic check_blk(input string what, input blk_idx_t got, input blk_idx_t exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0d ns: %s block %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_ref(input logic [7:0] gx, input logic [7:0] gy,
                             input logic [7:0] ex, input logic [7:0] ey);
        if (gx !== ex || gy !== ey) begin
            fail_run($sformatf("** Error at %0d ns: ref index %0d,%0d, expected %0d,%0d",
                               $time, gx, gy, ex, ey));
        end
    endtask

    task automatic check_ip(input ip_req_t got, input ip_req_t exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0d ns: ip_req_o %h, expected %h",
                               $time, got, exp));
        end
    endtask

    task automatic check_len(input string what, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("** Error at %0d ns: %s pass took %0d cycles, expected %0d",
                               $time, what, got, exp));
        end
    endtask

    // ************************************************************************
    // reference model
    // ************************************************************************
    // vertical split visits 0,2,1,3, the digit bits swapped
    function automatic logic [1:0] digit_at(input part_mode_t m, input logic [1:0] k);
        return (m == P_NX2N) ? {k[0], k[1]} : k;
    endfunction

    task automatic build_order(input fme_partition_t p);
        blk_idx_t b;
        order_q.delete();
        for (int i = 0; i < 4; i++) begin
            b.c32 = digit_at(p.p64, 2'(i));
            for (int j = 0; j < 4; j++) begin
                b.c16 = digit_at(p.p32[b.c32], 2'(j));
                for (int k = 0; k < 4; k++) begin
                    b.c08 = digit_at(p.p16[{b.c32, b.c16}], 2'(k));
                    order_q.push_back(b);
                end
            end
        end
    endtask

    function automatic blk_idx_t addr_to_blk(input logic [5:0] a);   // {y bits, x bits}
        blk_idx_t b;
        b.c32 = {a[5], a[2]};
        b.c16 = {a[4], a[1]};
        b.c08 = {a[3], a[0]};
        return b;
    endfunction

    function automatic logic [1:0] frac_code(input logic signed [W-1:0] mc,
                                             input logic signed [W-1:0] fi);
        if (mc == fi) begin
            return 2'b00;
        end
        return (mc > fi) ? 2'b01 : 2'b11;
    endfunction

    // memories answer one cycle after the read enable and hold their data
    task automatic next_cycle(input logic start, input logic cost);
        fime_rd = {fimeif_mv_rden_o === 1'b1, fimeif_mv_rdaddr_o};
        mc_rd   = {mcif_mv_rden_o === 1'b1, mcif_mv_rdaddr_o};
        @(posedge clk);
        cycles++;
        if (cycles > limit) begin
            fail_run($sformatf("controller hung, run went past %0d cycles", limit));
        end
        #1;
        sysif_start_i      = start;
        cost_done_i        = cost;
        fimeif_partition_i = part_cur;
        if (fime_rd[6]) begin
            fimeif_mv_data_i = fime_mem[fime_rd[5:0]];
        end
        if (mc_rd[6]) begin
            mcif_mv_data_i = mc_mem[mc_rd[5:0]];
        end
        @(negedge clk);                 // outputs sampled here
    endtask

    task automatic run_pass(input logic quar, output int len);
        blk_idx_t   b;
        ip_req_t    exp_req;
        ip_mv_t     imv;
        logic [5:0] a;
        int         ex;
        int         ey;
        len = 0;
        foreach (order_q[k]) begin
            b = order_q[k];
            check_ctrl({1'b1, quar, 1'b0, 1'b0});
            check_done(sysif_done_o, 1'b0);
            check_blk("fime read", addr_to_blk(fimeif_mv_rdaddr_o), b);
            if (quar) begin
                check_blk("mc read", addr_to_blk(mcif_mv_rdaddr_o), b);
            end
            a   = fimeif_mv_rdaddr_o;
            imv = fime_mem[a];
            exp_req.mv     = quar ? mc_mem[a] : imv;
            exp_req.frac_x = quar ? frac_code(mc_mem[a].x, imv.x) : 2'b00;
            exp_req.frac_y = quar ? frac_code(mc_mem[a].y, imv.y) : 2'b00;
            exp_req.half   = !quar;
            exp_req.idx    = b;
            ex = (int'(imv.x) >>> 2) + 8 * int'({b.c32[0], b.c16[0], b.c08[0]}) + REF_ORG_X_DEF;
            ey = (int'(imv.y) >>> 2) + 8 * int'({b.c32[1], b.c16[1], b.c08[1]}) + REF_ORG_Y_DEF;
            next_cycle(1'b0, 1'b0);
            len++;
            for (int r = 0; r < 16; r++) begin
                check_ctrl({1'b0, 1'b0, 1'b1, r == 0});
                if (r == 0) begin
                    check_ip(ip_req_o, exp_req);
                end
                check_ref(ref_idx_x_o, ref_idx_y_o, 8'(ex), 8'(ey + r));
                next_cycle(1'b0, 1'b0);
                len++;
            end
        end
        // pass ends when the reads stop
        while (fimeif_mv_rden_o === 1'b1 || ref_rden_o === 1'b1) begin
            next_cycle(1'b0, 1'b0);
            len++;
        end
    endtask

    task automatic wait_cost(input int delay, input logic quar);
        for (int i = 0; i <= delay; i++) begin
            check_ctrl(4'b0000);        // no reads while costs are compared
            check_done(sysif_done_o, 1'b0);
            next_cycle(1'b0, i == delay);
        end
        check_ctrl(4'b0000);
        next_cycle(1'b0, 1'b0);
        if (quar) begin
            check_done(sysif_done_o, 1'b1);
            next_cycle(1'b0, 1'b0);
            check_done(sysif_done_o, 1'b0);
        end
    endtask

    task automatic run_test(input fme_partition_t p, input int delay, input int exp_len);
        int len;
        part_cur = p;
        build_order(p);
        next_cycle(1'b0, 1'b0);
        next_cycle(1'b1, 1'b0);         // start pulse
        check_ctrl(4'b0000);
        next_cycle(1'b0, 1'b0);
        run_pass(1'b0, len);
        check_len("half", len, exp_len);
        wait_cost(delay, 1'b0);
        run_pass(1'b1, len);
        check_len("quarter", len, exp_len);
        wait_cost(delay, 1'b1);
    endtask

    // ************************************************************************
    // main sequence
    // ************************************************************************
    initial begin
        fme_partition_t parts [$];
        int             delays [$];
        int             lens [$];
        logic [41:0]    p_raw;
        string          line;
        int             fd;
        int             d;
        int             l;

        rstn               = 1'b0;
        sysif_start_i      = 1'b0;
        cost_done_i        = 1'b0;
        fimeif_partition_i = '0;
        fimeif_mv_data_i   = '0;
        mcif_mv_data_i     = '0;
        part_cur           = '0;
        cycles             = 0;
        limit              = 200;
        void'($urandom(32'hb2c8));
        for (int i = 0; i < 64; i++) begin
            fime_mem[i].x = W'($urandom);
            fime_mem[i].y = W'($urandom);
            // mc mv one step around fime mv, so every frac code shows up
            mc_mem[i].x   = fime_mem[i].x + W'($urandom_range(2)) - W'(1);
            mc_mem[i].y   = fime_mem[i].y + W'($urandom_range(2)) - W'(1);
        end

        fd = $fopen("tb_fme_input.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open tb_fme_input.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line[0] != "#" && $sscanf(line, "%h %d %d", p_raw, d, l) == 3) begin
                parts.push_back(p_raw);
                delays.push_back(d);
                lens.push_back(l);
            end
        end
        $fclose(fd);
        if (parts.size() == 0) begin
            fail_run("tb_fme_input.txt holds no tests");
        end
        limit = parts.size() * 2500 + 200;  // two passes and cost waits per ctu

        next_cycle(1'b0, 1'b0);
        check_ctrl(4'b0000);            // quiet in reset
        check_done(sysif_done_o, 1'b0);
        @(posedge clk);
        #1 rstn = 1'b1;
        @(negedge clk);
        foreach (parts[t]) begin
            run_test(parts[t], delays[t], lens[t]);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: fme_ctrl_top.sv
// fractional motion estimation controller
// half then quarter pass over the 64 8x8 blocks of one 64x64 ctu
module fme_ctrl_top #(
    parameter int FMV_WIDTH = fme_pkg::FMV_WIDTH_DEF,
    parameter int REF_ORG_X = fme_pkg::REF_ORG_X_DEF,
    parameter int REF_ORG_Y = fme_pkg::REF_ORG_Y_DEF
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    sysif_start_i,
    input  fme_pkg::fme_partition_t fimeif_partition_i,
    input  logic [2*FMV_WIDTH-1:0]  fimeif_mv_data_i,
    input  logic [2*FMV_WIDTH-1:0]  mcif_mv_data_i,
    input  logic                    cost_done_i,
    output logic                    sysif_done_o,
    output logic                    fimeif_mv_rden_o,
    output logic [5:0]              fimeif_mv_rdaddr_o,
    output logic                    mcif_mv_rden_o,
    output logic [5:0]              mcif_mv_rdaddr_o,
    output logic                    ref_rden_o,
    output logic [7:0]              ref_idx_x_o,
    output logic [7:0]              ref_idx_y_o,
    output logic                    ip_start_o,
    output fme_pkg::ip_req_t        ip_req_o
);
    import fme_pkg::*;

    fme_phase_t phase;
    blk_idx_t   blk;
    logic [3:0] row;
    logic       pass_last;              // last row of block 63
    logic       mv_rden;

    // ************************************************************************
    // pass sequencing
    // ************************************************************************
    fme_phase_fsm fme_phase_fsm_inst (
        .clk         (clk),
        .rstn        (rstn),
        .start_i     (sysif_start_i),
        .pass_last_i (pass_last),
        .cost_done_i (cost_done_i),
        .phase_o     (phase),
        .done_o      (sysif_done_o)
    );

    fme_block_walker fme_block_walker_inst (
        .clk         (clk),
        .rstn        (rstn),
        .phase_i     (phase),
        .partition_i (fimeif_partition_i),
        .blk_o       (blk),
        .row_o       (row),
        .mv_rden_o   (mv_rden),
        .ip_start_o  (ip_start_o),
        .ref_rden_o  (ref_rden_o),
        .pass_last_o (pass_last)
    );

    fme_mv_path #(
        .FMV_WIDTH (FMV_WIDTH),
        .REF_ORG_X (REF_ORG_X),
        .REF_ORG_Y (REF_ORG_Y)
    ) fme_mv_path_inst (
        .phase_i       (phase),
        .blk_i         (blk),
        .row_i         (row),
        .mv_rden_i     (mv_rden),
        .fime_mv_i     (fimeif_mv_data_i),
        .mc_mv_i       (mcif_mv_data_i),
        .fime_rdaddr_o (fimeif_mv_rdaddr_o),
        .mc_rden_o     (mcif_mv_rden_o),
        .mc_rdaddr_o   (mcif_mv_rdaddr_o),
        .ref_idx_x_o   (ref_idx_x_o),
        .ref_idx_y_o   (ref_idx_y_o),
        .ip_req_o      (ip_req_o)
    );

    assign fimeif_mv_rden_o = mv_rden;

endmodule

// File: fme_mv_path.sv
// fme motion vector path
// mv memory addressing, reference row address and interpolation request
module fme_mv_path #(
    parameter int FMV_WIDTH = fme_pkg::FMV_WIDTH_DEF,
    parameter int REF_ORG_X = fme_pkg::REF_ORG_X_DEF,
    parameter int REF_ORG_Y = fme_pkg::REF_ORG_Y_DEF
) (
    input  fme_pkg::fme_phase_t  phase_i,
    input  fme_pkg::blk_idx_t    blk_i,
    input  logic [3:0]           row_i,
    input  logic                 mv_rden_i,
    input  logic [2*FMV_WIDTH-1:0] fime_mv_i,
    input  logic [2*FMV_WIDTH-1:0] mc_mv_i,
    output logic [5:0]           fime_rdaddr_o,
    output logic                 mc_rden_o,
    output logic [5:0]           mc_rdaddr_o,
    output logic [7:0]           ref_idx_x_o,
    output logic [7:0]           ref_idx_y_o,
    output fme_pkg::ip_req_t     ip_req_o
);
    import fme_pkg::*;

    typedef struct packed {
        logic signed [FMV_WIDTH-1:0] x;
        logic signed [FMV_WIDTH-1:0] y;
    } fme_mv_t;

    fme_mv_t    imv;                    // integer search result
    fme_mv_t    fmv;                    // best half-pel result
    fme_mv_t    sel_mv;
    logic [2:0] pos_x;                  // 8x8 column in the ctu
    logic [2:0] pos_y;

    // 00 same, 01 right/down of imv, 11 left/up
    function automatic logic [1:0] frac_dir(input logic signed [FMV_WIDTH-1:0] f,
                                            input logic signed [FMV_WIDTH-1:0] i);
        if (f == i) begin
            frac_dir = 2'b00;
        end else if (f > i) begin
            frac_dir = 2'b01;
        end else begin
            frac_dir = 2'b11;
        end
    endfunction

    assign imv   = fime_mv_i;
    assign fmv   = mc_mv_i;
    assign pos_x = {blk_i.c32[0], blk_i.c16[0], blk_i.c08[0]};
    assign pos_y = {blk_i.c32[1], blk_i.c16[1], blk_i.c08[1]};

    assign fime_rdaddr_o = {pos_y, pos_x};
    assign mc_rdaddr_o   = {pos_y, pos_x};
    assign mc_rden_o     = mv_rden_i && ((phase_i == PH_PRE_QUAR) || (phase_i == PH_QUAR));

    // integer part of imv, wraps in the 256 wide buffer
    assign ref_idx_x_o = imv.x[9:2] + {2'b0, pos_x, 3'b0} + 8'(REF_ORG_X);
    assign ref_idx_y_o = imv.y[9:2] + {2'b0, pos_y, 3'b0} + {4'b0, row_i} + 8'(REF_ORG_Y);

    assign ip_req_o.half = (phase_i == PH_HALF) || (phase_i == PH_DONE_HALF);
    assign sel_mv        = ip_req_o.half ? imv : fmv;
    assign ip_req_o.mv.x = FMV_WIDTH_DEF'(sel_mv.x);
    assign ip_req_o.mv.y = FMV_WIDTH_DEF'(sel_mv.y);
    assign ip_req_o.frac_x = ip_req_o.half ? 2'b00 : frac_dir(fmv.x, imv.x);
    assign ip_req_o.frac_y = ip_req_o.half ? 2'b00 : frac_dir(fmv.y, imv.y);
    assign ip_req_o.idx  = blk_i;

    always_comb begin
        a_frac_code: assert ((ip_req_o.frac_x != 2'b10) && (ip_req_o.frac_y != 2'b10))
            else $error("fme: illegal frac code");
    end

endmodule

// File: fme_block_walker.sv
// fme 8x8 block walker
// steps the ctu block index in partition order and issues mv and row reads
module fme_block_walker (
    input  logic                    clk,
    input  logic                    rstn,
    input  fme_pkg::fme_phase_t     phase_i,
    input  fme_pkg::fme_partition_t partition_i,
    output fme_pkg::blk_idx_t       blk_o,
    output logic [3:0]              row_o,
    output logic                    mv_rden_o,
    output logic                    ip_start_o,
    output logic                    ref_rden_o,
    output logic                    pass_last_o
);
    import fme_pkg::*;

    blk_idx_t   blk_q;
    logic [3:0] row_q;
    logic       pre_ph;
    logic       act_ph;
    logic       clr_ph;                 // idle or cost wait
    logic       row_end;
    part_mode_t mode32;
    part_mode_t mode16;

    // z order, or 0,2,1,3 when the governing level is split vertically
    function automatic logic [1:0] next_digit(input logic [1:0] d, input part_mode_t mode);
        logic nx2n;
        nx2n = (mode == P_NX2N);
        case (d)
            2'd0:    next_digit = nx2n ? 2'd2 : 2'd1;
            2'd1:    next_digit = nx2n ? 2'd3 : 2'd2;
            2'd2:    next_digit = nx2n ? 2'd1 : 2'd3;
            default: next_digit = 2'd0;
        endcase
    endfunction

    assign pre_ph  = (phase_i == PH_PRE_HALF) || (phase_i == PH_PRE_QUAR);
    assign act_ph  = (phase_i == PH_HALF) || (phase_i == PH_QUAR);
    assign clr_ph  = (phase_i == PH_IDLE) || (phase_i == PH_DONE_HALF)
                  || (phase_i == PH_DONE_QUAR);
    assign row_end = (row_q == 4'd15);

    assign mode32 = partition_i.p32[blk_q.c32];
    assign mode16 = partition_i.p16[{blk_q.c32, blk_q.c16}];

    // ************************************************************************
    // block index, c08 fastest
    // ************************************************************************
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            blk_q <= '0;
        end else if (clr_ph) begin
            blk_q <= '0;
        end else if (row_end) begin
            blk_q.c08 <= next_digit(blk_q.c08, mode16);
            if (blk_q.c08 == 2'd3) begin
                blk_q.c16 <= next_digit(blk_q.c16, mode32);
                if (blk_q.c16 == 2'd3) begin
                    blk_q.c32 <= next_digit(blk_q.c32, partition_i.p64);
                end
            end
        end
    end

    // row counter, restarts with every mv fetch
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            row_q <= 4'd0;
        end else if (clr_ph || mv_rden_o) begin
            row_q <= 4'd0;
        end else begin
            row_q <= row_q + 4'd1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ip_start_o <= 1'b0;
        end else begin
            ip_start_o <= mv_rden_o;    // mv data valid now
        end
    end

    // slot: mv read, then rows 0..15
    assign mv_rden_o   = pre_ph || (act_ph && (row_q == 4'd0) && !ip_start_o);
    assign ref_rden_o  = act_ph && !mv_rden_o;
    assign pass_last_o = act_ph && row_end && (blk_q == '1);
    assign blk_o       = blk_q;
    assign row_o       = row_q;

    a_mv_on_row0: assert property (@(posedge clk) disable iff (!rstn)
        mv_rden_o |-> (row_q == 4'd0));

endmodule

// File: fme_phase_fsm.sv
// fme pass sequencer
// idle -> half pass -> cost wait -> quarter pass -> cost wait -> idle
module fme_phase_fsm (
    input  logic               clk,
    input  logic               rstn,
    input  logic               start_i,
    input  logic               pass_last_i,
    input  logic               cost_done_i,
    output fme_pkg::fme_phase_t phase_o,
    output logic               done_o
);
    import fme_pkg::*;

    fme_phase_t phase_q;
    fme_phase_t phase_d;

    // ************************************************************************
    // next phase
    // ************************************************************************
    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            PH_IDLE: begin
                if (start_i) begin
                    phase_d = PH_PRE_HALF;
                end
            end
            PH_PRE_HALF:  phase_d = PH_HALF;     // single mv fetch cycle
            PH_HALF: begin
                if (pass_last_i) begin
                    phase_d = PH_DONE_HALF;
                end
            end
            PH_DONE_HALF: begin
                if (cost_done_i) begin       // half costs compared
                    phase_d = PH_PRE_QUAR;
                end
            end
            PH_PRE_QUAR:  phase_d = PH_QUAR;
            PH_QUAR: begin
                if (pass_last_i) begin
                    phase_d = PH_DONE_QUAR;
                end
            end
            PH_DONE_QUAR: begin
                if (cost_done_i) begin
                    phase_d = PH_IDLE;
                end
            end
            default:      phase_d = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase_q <= PH_IDLE;
            done_o  <= 1'b0;
        end else begin
            phase_q <= phase_d;
            done_o  <= (phase_q == PH_DONE_QUAR) && cost_done_i;  // ctu finished
        end
    end

    assign phase_o = phase_q;

    // fsm leaves the quarter wait on the same edge, so no second pulse
    a_done_single: assert property (@(posedge clk) disable iff (!rstn)
        done_o |=> !done_o);

endmodule

// File: fme_pkg.sv
// fractional motion estimation controller, shared types
// partition codes, phase encoding, block index and interpolation request
package fme_pkg;

    // ************************************************************************
    // defaults, overridden from the top level
    // ************************************************************************
    localparam int FMV_WIDTH_DEF = 10;  // signed quarter-pel component, >= 10
    localparam int REF_ORG_X_DEF = 60;  // search window origin in ref buffer
    localparam int REF_ORG_Y_DEF = 28;

    // partition code from integer search
    typedef enum logic [1:0] {
        P_2NX2N = 2'd0,
        P_2NXN  = 2'd1,
        P_NX2N  = 2'd2,
        P_SPLIT = 2'd3
    } part_mode_t;

    // msb first: p16[15] sits at [41:40], p64 at [1:0]
    typedef struct packed {
        part_mode_t [15:0] p16;         // indexed by {c32, c16}
        part_mode_t [3:0]  p32;         // indexed by c32
        part_mode_t        p64;
    } fme_partition_t;

    typedef enum logic [2:0] {
        PH_IDLE      = 3'd0,
        PH_PRE_HALF  = 3'd1,
        PH_HALF      = 3'd2,
        PH_DONE_HALF = 3'd3,
        PH_PRE_QUAR  = 3'd4,
        PH_QUAR      = 3'd5,
        PH_DONE_QUAR = 3'd6
    } fme_phase_t;

    // per digit: bit 0 is the x half, bit 1 the y half
    typedef struct packed {
        logic [1:0] c32;
        logic [1:0] c16;
        logic [1:0] c08;
    } blk_idx_t;

    // modules declare their own mv type with the same layout, sized by
    // FMV_WIDTH:  struct packed { signed [W-1:0] x; signed [W-1:0] y; }
    typedef struct packed {
        logic signed [FMV_WIDTH_DEF-1:0] x;
        logic signed [FMV_WIDTH_DEF-1:0] y;
    } ip_mv_t;

    typedef struct packed {
        ip_mv_t     mv;
        logic [1:0] frac_x;             // 00 same, 01 plus, 11 minus
        logic [1:0] frac_y;
        logic       half;               // half-pel pass
        blk_idx_t   idx;
    } ip_req_t;

endpackage
